// File: logic/io_bridge_cfg.svh
`ifndef IO_BRIDGE_CFG_SVH
`define IO_BRIDGE_CFG_SVH

// I/O side of the bridge
`define IO_DATA_WIDTH 64
`define IO_ADDR_WIDTH 32

// Internal AXI4-Lite bus
`define AXIL_DATA_WIDTH 32
`define AXIL_ADDR_WIDTH 32

// Number of 32-bit registers behind the bus
`define REG_COUNT 16

`endif

// File: logic/io_bridge_pkg.sv
`include "io_bridge_cfg.svh"

package io_bridge_pkg;

  typedef logic [`IO_ADDR_WIDTH-1:0]     io_addr_t;
  typedef logic [`IO_DATA_WIDTH-1:0]     io_data_t;
  typedef logic [`AXIL_DATA_WIDTH-1:0]   axil_data_t;
  typedef logic [`AXIL_DATA_WIDTH/8-1:0] axil_strb_t;

  // Command message types
  typedef logic [1:0] io_msg_t;
  localparam io_msg_t MSG_RD    = 2'b00;
  localparam io_msg_t MSG_WR    = 2'b01;
  localparam io_msg_t MSG_UC_RD = 2'b10;
  localparam io_msg_t MSG_UC_WR = 2'b11;

  // Size as log2 of the byte count
  typedef logic [1:0] io_size_t;
  localparam io_size_t SIZE_1 = 2'b00;
  localparam io_size_t SIZE_2 = 2'b01;
  localparam io_size_t SIZE_4 = 2'b10;

  typedef logic [1:0] axil_resp_t;
  localparam axil_resp_t RESP_OKAY   = 2'b00;
  localparam axil_resp_t RESP_SLVERR = 2'b10;

  typedef enum logic [2:0] {
    READY,
    WRITE_ADDR_TX,
    WRITE_DATA_TX,
    WRITE_RESP_RX,
    READ_DATA_RX
  } master_state_e;

endpackage

// File: logic/axil_if.sv
`timescale 1ns/100ps
`include "io_bridge_cfg.svh"

interface axil_if;
  import io_bridge_pkg::*;

  // Write address channel
  logic [`AXIL_ADDR_WIDTH-1:0] awaddr;
  logic                        awvalid;
  logic                        awready;

  // Write data channel
  axil_data_t                  wdata;
  axil_strb_t                  wstrb;
  logic                        wvalid;
  logic                        wready;

  // Write response channel
  axil_resp_t                  bresp;
  logic                        bvalid;
  logic                        bready;

  // Read address channel
  logic [`AXIL_ADDR_WIDTH-1:0] araddr;
  logic                        arvalid;
  logic                        arready;

  // Read data channel
  axil_data_t                  rdata;
  axil_resp_t                  rresp;
  logic                        rvalid;
  logic                        rready;

  modport master (
    output awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
    input  awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
  );

  modport slave (
    input  awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
    output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
  );

endinterface

// File: logic/axil_io_master.sv
`timescale 1ns/100ps
`include "io_bridge_cfg.svh"

module axil_io_master (
  input  logic                     clk_i,
  input  logic                     reset_i,

  input  io_bridge_pkg::io_msg_t   cmd_msg_i,
  input  io_bridge_pkg::io_addr_t  cmd_addr_i,
  input  io_bridge_pkg::io_size_t  cmd_size_i,
  input  io_bridge_pkg::io_data_t  cmd_data_i,
  input  logic                     cmd_v_i,
  output logic                     cmd_yumi_o,

  output io_bridge_pkg::io_msg_t   resp_msg_o,
  output io_bridge_pkg::io_addr_t  resp_addr_o,
  output io_bridge_pkg::io_size_t  resp_size_o,
  output logic                     resp_v_o,
  output logic                     resp_err_o,
  input  logic                     resp_ready_i,

  axil_if.master                   axil
);
  import io_bridge_pkg::*;

  master_state_e state_r;
  master_state_e state_n;
  axil_strb_t    strb_base;
  logic          is_write;

  assign is_write = cmd_msg_i inside {MSG_WR, MSG_UC_WR};

  // Response header is the held command header
  assign resp_msg_o  = cmd_msg_i;
  assign resp_addr_o = cmd_addr_i;
  assign resp_size_o = cmd_size_i;

  // Payload follows the command directly
  assign axil.awaddr = cmd_addr_i;
  assign axil.araddr = cmd_addr_i;
  assign axil.wdata  = cmd_data_i[`AXIL_DATA_WIDTH-1:0];

  // Strobe ones for the size, then moved to the addressed lane
  always_comb
  begin
    case (cmd_size_i)
      SIZE_1:  strb_base = 4'b0001;
      SIZE_2:  strb_base = 4'b0011;
      default: strb_base = 4'b1111;
    endcase
  end

  assign axil.wstrb = strb_base << cmd_addr_i[1:0];

  always_comb
  begin
    state_n      = state_r;
    cmd_yumi_o   = 1'b0;
    resp_v_o     = 1'b0;
    resp_err_o   = 1'b0;
    axil.awvalid = 1'b0;
    axil.wvalid  = 1'b0;
    axil.bready  = 1'b0;
    axil.arvalid = 1'b0;
    axil.rready  = 1'b0;

    case (state_r)
      READY:
      begin
        if (cmd_v_i && is_write)
        begin
          axil.awvalid = 1'b1;
          axil.wvalid  = 1'b1;
          // Whichever channel is left over gets its own state
          if (axil.awready && axil.wready)
            state_n = WRITE_RESP_RX;
          else if (axil.awready)
            state_n = WRITE_DATA_TX;
          else if (axil.wready)
            state_n = WRITE_ADDR_TX;
        end
        else if (cmd_v_i)
        begin
          axil.arvalid = 1'b1;
          if (axil.arready)
            state_n = READ_DATA_RX;
        end
      end

      WRITE_ADDR_TX:
      begin
        axil.awvalid = 1'b1;
        if (axil.awready)
          state_n = WRITE_RESP_RX;
      end

      WRITE_DATA_TX:
      begin
        axil.wvalid = 1'b1;
        if (axil.wready)
          state_n = WRITE_RESP_RX;
      end

      WRITE_RESP_RX:
      begin
        // B beat and I/O response retire together
        axil.bready = resp_ready_i;
        resp_v_o    = axil.bvalid;
        resp_err_o  = axil.bvalid && (axil.bresp == RESP_SLVERR);
        cmd_yumi_o  = axil.bvalid && resp_ready_i;
        if (cmd_yumi_o)
          state_n = READY;
      end

      READ_DATA_RX:
      begin
        axil.rready = resp_ready_i;
        resp_v_o    = axil.rvalid;
        resp_err_o  = axil.rvalid && (axil.rresp == RESP_SLVERR);
        cmd_yumi_o  = axil.rvalid && resp_ready_i;
        if (cmd_yumi_o)
          state_n = READY;
      end

      default:
      begin
        state_n = READY;
      end
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= READY;
    else
      state_r <= state_n;
  end

endmodule

// File: logic/resp_lane_pack.sv
`timescale 1ns/100ps
`include "io_bridge_cfg.svh"

module resp_lane_pack (
  input  io_bridge_pkg::axil_data_t rdata_i,
  input  logic [1:0]                offset_i,
  input  io_bridge_pkg::io_size_t   size_i,
  output io_bridge_pkg::io_data_t   data_o
);
  import io_bridge_pkg::*;

  axil_data_t shifted;

  // Addressed byte moved down to bit 0
  assign shifted = rdata_i >> (8 * offset_i);

  // Narrow data repeated to fill the whole I/O word
  always_comb
  begin
    case (size_i)
      SIZE_1:
        data_o = {(`IO_DATA_WIDTH / 8){shifted[7:0]}};
      SIZE_2:
        data_o = {(`IO_DATA_WIDTH / 16){shifted[15:0]}};
      default:
        data_o = {(`IO_DATA_WIDTH / `AXIL_DATA_WIDTH){shifted}};
    endcase
  end

endmodule

// File: logic/axil_reg_file.sv
`timescale 1ns/100ps
`include "io_bridge_cfg.svh"

module axil_reg_file (
  input  logic   clk_i,
  input  logic   reset_i,
  axil_if.slave  axil
);
  import io_bridge_pkg::*;

  localparam int IDX_W = $clog2(`REG_COUNT);
  localparam int BYTES = `AXIL_DATA_WIDTH / 8;
  localparam logic [`AXIL_ADDR_WIDTH-1:0] ADDR_LIMIT = `AXIL_ADDR_WIDTH'(`REG_COUNT * 4);

  axil_data_t                  regs_r [`REG_COUNT];
  logic [`AXIL_ADDR_WIDTH-1:0] awaddr_r;
  logic                        aw_held_r;
  logic                        bvalid_r;
  axil_resp_t                  bresp_r;
  logic                        rvalid_r;
  axil_resp_t                  rresp_r;
  axil_data_t                  rdata_r;
  logic                        w_fire;
  logic                        ar_fire;
  logic                        w_in_range;
  logic                        r_in_range;

  // Data is accepted only after its address is held
  assign axil.awready = ~aw_held_r;
  assign axil.wready  = aw_held_r & ~bvalid_r;
  assign axil.arready = ~rvalid_r;

  assign axil.bvalid = bvalid_r;
  assign axil.bresp  = bresp_r;
  assign axil.rvalid = rvalid_r;
  assign axil.rresp  = rresp_r;
  assign axil.rdata  = rdata_r;

  assign w_fire     = axil.wvalid & axil.wready;
  assign ar_fire    = axil.arvalid & axil.arready;
  assign w_in_range = awaddr_r < ADDR_LIMIT;
  assign r_in_range = axil.araddr < ADDR_LIMIT;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      aw_held_r <= 1'b0;
      bvalid_r  <= 1'b0;
      rvalid_r  <= 1'b0;
    end
    else
    begin
      if (axil.awvalid && axil.awready)
        aw_held_r <= 1'b1;
      else if (w_fire)
        aw_held_r <= 1'b0;

      if (w_fire)
        bvalid_r <= 1'b1;
      else if (axil.bready)
        bvalid_r <= 1'b0;

      if (ar_fire)
        rvalid_r <= 1'b1;
      else if (axil.rready)
        rvalid_r <= 1'b0;
    end
  end

  // Response payload, loaded with its valid
  always_ff @(posedge clk_i)
  begin
    if (axil.awvalid && axil.awready)
      awaddr_r <= axil.awaddr;
    if (w_fire)
      bresp_r <= w_in_range ? RESP_OKAY : RESP_SLVERR;
    if (ar_fire)
    begin
      rresp_r <= r_in_range ? RESP_OKAY : RESP_SLVERR;
      rdata_r <= r_in_range ? regs_r[axil.araddr[IDX_W+1:2]] : '0;
    end
  end

  // Strobed byte writes, out-of-range writes dropped
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int i = 0; i < `REG_COUNT; i++)
        regs_r[i] <= '0;
    end
    else if (w_fire && w_in_range)
    begin
      for (int b = 0; b < BYTES; b++)
        if (axil.wstrb[b])
          regs_r[awaddr_r[IDX_W+1:2]][8*b +: 8] <= axil.wdata[8*b +: 8];
    end
  end

endmodule

// File: logic/io_bridge_top.sv
`timescale 1ns/100ps

module io_bridge_top (
  input  logic                     clk_i,
  input  logic                     reset_i,

  input  io_bridge_pkg::io_msg_t   cmd_msg_i,
  input  io_bridge_pkg::io_addr_t  cmd_addr_i,
  input  io_bridge_pkg::io_size_t  cmd_size_i,
  input  io_bridge_pkg::io_data_t  cmd_data_i,
  input  logic                     cmd_v_i,
  output logic                     cmd_yumi_o,

  output io_bridge_pkg::io_msg_t   resp_msg_o,
  output io_bridge_pkg::io_addr_t  resp_addr_o,
  output io_bridge_pkg::io_size_t  resp_size_o,
  output io_bridge_pkg::io_data_t  resp_data_o,
  output logic                     resp_err_o,
  output logic                     resp_v_o,
  input  logic                     resp_ready_i
);

  axil_if axil ();

  axil_io_master u_master (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .cmd_msg_i    (cmd_msg_i),
    .cmd_addr_i   (cmd_addr_i),
    .cmd_size_i   (cmd_size_i),
    .cmd_data_i   (cmd_data_i),
    .cmd_v_i      (cmd_v_i),
    .cmd_yumi_o   (cmd_yumi_o),
    .resp_msg_o   (resp_msg_o),
    .resp_addr_o  (resp_addr_o),
    .resp_size_o  (resp_size_o),
    .resp_v_o     (resp_v_o),
    .resp_err_o   (resp_err_o),
    .resp_ready_i (resp_ready_i),
    .axil         (axil.master)
  );

  // Read data lane select uses the held command fields
  resp_lane_pack u_lane_pack (
    .rdata_i  (axil.rdata),
    .offset_i (cmd_addr_i[1:0]),
    .size_i   (cmd_size_i),
    .data_o   (resp_data_o)
  );

  axil_reg_file u_reg_file (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .axil    (axil.slave)
  );

endmodule

// File: dv/io_bridge_assert.sv
`timescale 1ns/100ps

module io_bridge_assert (
  input logic                          clk_i,
  input logic                          reset_i,
  input io_bridge_pkg::master_state_e  state_i,
  input logic                          awvalid_i,
  input logic                          awready_i,
  input logic                          arvalid_i,
  input logic                          arready_i,
  input logic                          cmd_yumi_i,
  input logic                          resp_v_i,
  input logic                          resp_ready_i,
  input io_bridge_pkg::io_addr_t       resp_addr_i
);
  import io_bridge_pkg::*;

  // Failures seen so far
  int fail_count = 0;

  aw_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    awvalid_i && !awready_i |=> awvalid_i)
    else
    begin
      fail_count++;
      $error("awvalid dropped before awready");
    end

  ar_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    arvalid_i && !arready_i |=> arvalid_i)
    else
    begin
      fail_count++;
      $error("arvalid dropped before arready");
    end

  // Stalled response keeps its valid and address
  resp_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_v_i && !resp_ready_i |=> resp_v_i && $stable(resp_addr_i))
    else
    begin
      fail_count++;
      $error("response changed while resp_ready_i was low");
    end

  yumi_on_accept: assert property (@(posedge clk_i) disable iff (reset_i)
    cmd_yumi_i |-> resp_v_i && resp_ready_i)
    else
    begin
      fail_count++;
      $error("cmd_yumi_o without an accepted response");
    end

  aw_ar_exclusive: assert property (@(posedge clk_i) disable iff (reset_i)
    !(awvalid_i && arvalid_i))
    else
    begin
      fail_count++;
      $error("awvalid and arvalid high together");
    end

  // Slave raises bvalid or rvalid on the edge that enters the wait state
  resp_in_wait: assert property (@(posedge clk_i) disable iff (reset_i)
    state_i inside {WRITE_RESP_RX, READ_DATA_RX} |-> resp_v_i)
    else
    begin
      fail_count++;
      $error("no response valid while waiting for B or R");
    end

endmodule

bind axil_io_master io_bridge_assert u_assert (
  .clk_i        (clk_i),
  .reset_i      (reset_i),
  .state_i      (state_r),
  .awvalid_i    (axil.awvalid),
  .awready_i    (axil.awready),
  .arvalid_i    (axil.arvalid),
  .arready_i    (axil.arready),
  .cmd_yumi_i   (cmd_yumi_o),
  .resp_v_i     (resp_v_o),
  .resp_ready_i (resp_ready_i),
  .resp_addr_i  (resp_addr_o)
);

// File: dv/io_bridge_tb.sv
`timescale 1ns/100ps
`include "io_bridge_cfg.svh"

module io_bridge_tb;
  import io_bridge_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int DRIVE_DLY  = 1;
  // About 3000 cycles worst case over all tests, with margin
  localparam int TIMEOUT_CYCLES = 4000;

  logic       clk_i;
  logic       reset_i;
  io_msg_t    cmd_msg_i;
  io_addr_t   cmd_addr_i;
  io_size_t   cmd_size_i;
  io_data_t   cmd_data_i;
  logic       cmd_v_i;
  logic       cmd_yumi_o;
  io_msg_t    resp_msg_o;
  io_addr_t   resp_addr_o;
  io_size_t   resp_size_o;
  io_data_t   resp_data_o;
  logic       resp_err_o;
  logic       resp_v_o;
  logic       resp_ready_i;

  axil_data_t model [`REG_COUNT];
  logic [31:0] rng_state;
  int         errors;
  int         checks;
  int         cycles;

  // Last accepted response
  io_msg_t    got_msg;
  io_addr_t   got_addr;
  io_size_t   got_size;
  io_data_t   got_data;
  logic       got_err;

  io_bridge_top u_dut (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .cmd_msg_i    (cmd_msg_i),
    .cmd_addr_i   (cmd_addr_i),
    .cmd_size_i   (cmd_size_i),
    .cmd_data_i   (cmd_data_i),
    .cmd_v_i      (cmd_v_i),
    .cmd_yumi_o   (cmd_yumi_o),
    .resp_msg_o   (resp_msg_o),
    .resp_addr_o  (resp_addr_o),
    .resp_size_o  (resp_size_o),
    .resp_data_o  (resp_data_o),
    .resp_err_o   (resp_err_o),
    .resp_v_o     (resp_v_o),
    .resp_ready_i (resp_ready_i)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial
  begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES)
    begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: run still going after %0d cycles, the DUT looks hung", cycles);
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display(">>> FAIL");
    $finish;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic int nbytes(input io_size_t size);
    case (size)
      SIZE_1:  return 1;
      SIZE_2:  return 2;
      default: return 4;
    endcase
  endfunction

  // Low bytes of value repeated over every lane of the I/O word
  function automatic io_data_t replicate(input axil_data_t value, input io_size_t size);
    io_data_t d;
    int       n;
    n = nbytes(size);
    for (int k = 0; k < 8; k++)
      d[8*k +: 8] = value[8*(k % n) +: 8];
    return d;
  endfunction

  function automatic io_data_t expect_read(input io_addr_t addr, input io_size_t size);
    axil_data_t word;
    io_data_t   d;
    int         n;
    int         off;
    word = (addr < `REG_COUNT * 4) ? model[addr >> 2] : '0;
    n    = nbytes(size);
    off  = addr % 4;
    for (int k = 0; k < 8; k++)
      d[8*k +: 8] = word[8*(off + k % n) +: 8];
    return d;
  endfunction

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("Error at %0d ns: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  // Drives one command and waits for its response, holding resp_ready_i low for stall cycles
  task automatic send(input io_msg_t msg, input io_addr_t addr, input io_size_t size,
                      input io_data_t data, input int stall, input logic is_read);
    int       held;
    int       yumis;
    logic     done;
    io_msg_t  hold_msg;
    io_addr_t hold_addr;
    io_data_t hold_data;
    logic     hold_err;
    held  = 0;
    yumis = 0;
    done  = 1'b0;
    cmd_msg_i    = msg;
    cmd_addr_i   = addr;
    cmd_size_i   = size;
    cmd_data_i   = data;
    cmd_v_i      = 1'b1;
    resp_ready_i = (stall == 0);
    while (!done)
    begin
      @(negedge clk_i);
      if (cmd_yumi_o)
        yumis++;
      if (resp_v_o && !resp_ready_i)
      begin
        if (held == 0)
        begin
          hold_msg  = resp_msg_o;
          hold_addr = resp_addr_o;
          hold_data = resp_data_o;
          hold_err  = resp_err_o;
        end
        held++;
      end
      else if (resp_v_o)
      begin
        done     = 1'b1;
        got_msg  = resp_msg_o;
        got_addr = resp_addr_o;
        got_size = resp_size_o;
        got_data = resp_data_o;
        got_err  = resp_err_o;
        check("cmd_yumi_o", 1, cmd_yumi_o);
      end
      if (held > 0)
      begin
        check("resp_v_o (held)", 1, resp_v_o);
        check("resp_msg_o (held)", hold_msg, resp_msg_o);
        check("resp_addr_o (held)", hold_addr, resp_addr_o);
        check("resp_err_o (held)", hold_err, resp_err_o);
        if (is_read)
          check("resp_data_o (held)", hold_data, resp_data_o);
      end
      @(posedge clk_i);
      #DRIVE_DLY;
      if (held >= stall)
        resp_ready_i = 1'b1;
    end
    cmd_v_i      = 1'b0;
    resp_ready_i = 1'b0;
    check("cmd_yumi_o pulse count", 1, yumis);
  endtask

  // One command checked against the model, which then takes the write
  task automatic issue(input io_msg_t msg, input io_addr_t addr, input io_size_t size,
                       input axil_data_t value, input int stall);
    logic     wr;
    logic     in_range;
    io_data_t exp_data;
    int       off;
    wr       = (msg == MSG_WR) || (msg == MSG_UC_WR);
    in_range = addr < `REG_COUNT * 4;
    exp_data = expect_read(addr, size);
    send(msg, addr, size, replicate(value, size), stall, !wr);
    check("resp_msg_o", msg, got_msg);
    check("resp_addr_o", addr, got_addr);
    check("resp_size_o", size, got_size);
    check("resp_err_o", !in_range, got_err);
    if (!wr)
      check("resp_data_o", exp_data, got_data);
    if (wr && in_range)
    begin
      off = addr % 4;
      for (int b = 0; b < nbytes(size); b++)
        model[addr >> 2][8*(off + b) +: 8] = value[8*b +: 8];
    end
  endtask

  task automatic random_cmd(input int word_span, input int stall_span);
    io_msg_t  msg;
    io_size_t size;
    int       off;
    io_addr_t addr;
    msg = io_msg_t'(next_rand() % 4);
    case (next_rand() % 3)
      0:       size = SIZE_1;
      1:       size = SIZE_2;
      default: size = SIZE_4;
    endcase
    off  = next_rand() % 4;
    off  = off - (off % nbytes(size));
    addr = (next_rand() % word_span) * 4 + off;
    issue(msg, addr, size, next_rand(), next_rand() % stall_span);
  endtask

  task automatic test_reset_state();
    @(negedge clk_i);
    check("cmd_yumi_o", 0, cmd_yumi_o);
    check("resp_v_o", 0, resp_v_o);
    @(posedge clk_i);
    #DRIVE_DLY;
  endtask

  task automatic test_full_words();
    for (int pass = 0; pass < 2; pass++)
    begin
      for (int i = 0; i < `REG_COUNT; i++)
        issue(pass ? MSG_UC_WR : MSG_WR, i * 4, SIZE_4, next_rand(), 0);
      for (int i = 0; i < `REG_COUNT; i++)
        issue(pass ? MSG_UC_RD : MSG_RD, i * 4, SIZE_4, 0, 0);
    end
  endtask

  // Spread over first, middle and last registers
  task automatic test_narrow();
    io_addr_t base;
    for (int i = 0; i < 4; i++)
    begin
      base = i * 5 * 4;
      for (int off = 0; off < 4; off++)
      begin
        issue(MSG_UC_WR, base + off, SIZE_1, next_rand(), 0);
        issue(MSG_RD, base + off, SIZE_1, 0, 0);
      end
      for (int off = 0; off < 4; off += 2)
      begin
        issue(MSG_WR, base + off, SIZE_2, next_rand(), 0);
        issue(MSG_UC_RD, base + off, SIZE_2, 0, 0);
      end
      issue(MSG_RD, base, SIZE_4, 0, 0);
    end
  endtask

  task automatic test_out_of_range();
    issue(MSG_WR, 64, SIZE_4, 32'hDEAD_BEEF, 0);
    issue(MSG_UC_WR, 65, SIZE_1, 32'h0000_00C3, 0);
    issue(MSG_WR, 32'hFFFF_FFFC, SIZE_4, 32'h1234_5678, 0);
    issue(MSG_RD, 64, SIZE_4, 0, 0);
    issue(MSG_UC_RD, 130, SIZE_2, 0, 0);
    for (int i = 0; i < `REG_COUNT; i++)
      issue(MSG_RD, i * 4, SIZE_4, 0, 0);
  endtask

  task automatic test_backpressure();
    for (int i = 0; i < 24; i++)
      random_cmd(`REG_COUNT, 8);
  endtask

  // Word span past the last register mixes in error responses
  task automatic test_random();
    for (int i = 0; i < 200; i++)
      random_cmd(`REG_COUNT + 4, 8);
  endtask

  initial
  begin
    reset_i      = 1'b1;
    cmd_msg_i    = MSG_RD;
    cmd_addr_i   = '0;
    cmd_size_i   = SIZE_1;
    cmd_data_i   = '0;
    cmd_v_i      = 1'b0;
    resp_ready_i = 1'b0;
    rng_state    = 32'd64028;
    errors       = 0;
    checks       = 0;
    for (int i = 0; i < `REG_COUNT; i++)
      model[i] = '0;
    repeat (3) @(posedge clk_i);
    #DRIVE_DLY;
    reset_i = 1'b0;

    test_reset_state();
    test_full_words();
    test_narrow();
    test_out_of_range();
    test_backpressure();
    test_random();

    errors = errors + u_dut.u_master.u_assert.fail_count;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

// File: compile.f
+incdir+logic
logic/io_bridge_pkg.sv
logic/axil_if.sv
logic/axil_io_master.sv
logic/resp_lane_pack.sv
logic/axil_reg_file.sv
logic/io_bridge_top.sv
dv/io_bridge_assert.sv
dv/io_bridge_tb.sv
